//--- kcpu_isa_pkg.sv
package kcpu_isa_pkg;

    // opcode subset
    localparam logic [7:0] NOP      = 8'h12;
    localparam logic [7:0] LDA_IMM  = 8'h86;
    localparam logic [7:0] ADDA_IMM = 8'h8b;
    localparam logic [7:0] LDD_IMM  = 8'hcc;
    localparam logic [7:0] INCA     = 8'h4c;
    localparam logic [7:0] CLRB     = 8'h5f;
    localparam logic [7:0] LDA_IDX  = 8'ha6;
    localparam logic [7:0] STA      = 8'ha7;
    localparam logic [7:0] LEAX     = 8'h30;
    localparam logic [7:0] BRA      = 8'h20;
    localparam logic [7:0] LBRA     = 8'h16;
    localparam logic [7:0] RTS      = 8'h39;
    localparam logic [7:0] JMP      = 8'h6e;

    // microcode routine categories, upper nibble of the microcode address
    typedef enum logic [3:0] {
        RESET          = 4'd0,
        NMI            = 4'd1,
        FIRQ           = 4'd2,
        IRQ            = 4'd3,
        NOPE           = 4'd4,
        SINGLE_ALU     = 4'd5,
        SINGLE_ALU_16  = 4'd6,
        SINGLE_A_INH   = 4'd7,
        PARSE_IDX      = 4'd8,
        SINGLE_ALU_IDX = 4'd9,
        STORE8         = 4'd10,
        LEA            = 4'd11,
        SBRANCH        = 4'd12,
        LBRANCH        = 4'd13,
        IDX_MODE       = 4'd14,
        BUSERROR       = 4'd15   // stop condition
    } cat_t;

    // condition code bits
    localparam int CC_I = 4;
    localparam int CC_F = 6;

    // indexed postbyte fields
    localparam int IDX_REG_LSB = 4;   // 3-bit register select
    localparam int IDX_IND_BIT = 3;   // indirect request

endpackage

//--- kcpu_ucode_pkg.sv
package kcpu_ucode_pkg;

    localparam int OPCAT_AW = 4;
    localparam int ROW_AW   = 4;
    localparam int UCODE_AW = OPCAT_AW + ROW_AW;   // {category, row}
    localparam int CTL_W    = 8;

    // every routine starts at its first row
    localparam logic [ROW_AW-1:0] ENTRY_ROW = '0;

    typedef struct packed {
        logic             fetch;     // read the next byte
        logic             pb;        // that byte is a postbyte
        logic             idx_jmp;
        logic             idx_ret;
        logic             ni;        // next instruction
        logic [CTL_W-1:0] ctl;       // datapath controls
    } ucode_t;

    // flag groups for the ROM table, order as in ucode_t
    localparam logic [4:0] UF_NONE    = 5'b00000;
    localparam logic [4:0] UF_FETCH   = 5'b10000;
    localparam logic [4:0] UF_PB      = 5'b11000;
    localparam logic [4:0] UF_IDX_JMP = 5'b00100;
    localparam logic [4:0] UF_IDX_RET = 5'b00010;
    localparam logic [4:0] UF_NI      = 5'b00001;

endpackage

//--- kcpu_wb_if.sv
`timescale 1ns/1ps

interface kcpu_wb_if;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [15:0] adr;
    logic [7:0]  dat_r;
    logic        ack;

    modport master (output cyc, stb, we, adr, input dat_r, ack);
    modport slave  (input cyc, stb, we, adr, output dat_r, ack);
endinterface

//--- kcpu_opdecode.sv
`timescale 1ns/1ps

module kcpu_opdecode (
    input  logic [7:0]         op,
    input  logic [7:0]         postbyte,
    output kcpu_isa_pkg::cat_t cat,
    output kcpu_isa_pkg::cat_t nx_cat,
    output kcpu_isa_pkg::cat_t idx_cat
);

    logic [2:0] idx_reg;

    assign idx_reg = postbyte[kcpu_isa_pkg::IDX_REG_LSB +: 3];

    // opcode to routine category
    always_comb begin
        nx_cat = kcpu_isa_pkg::NOPE;   // only indexed opcodes need a follow-up
        case (op)
            kcpu_isa_pkg::NOP,
            kcpu_isa_pkg::RTS:      cat = kcpu_isa_pkg::NOPE;   // no stack in this section
            kcpu_isa_pkg::LDA_IMM,
            kcpu_isa_pkg::ADDA_IMM: cat = kcpu_isa_pkg::SINGLE_ALU;
            kcpu_isa_pkg::LDD_IMM:  cat = kcpu_isa_pkg::SINGLE_ALU_16;
            kcpu_isa_pkg::INCA,
            kcpu_isa_pkg::CLRB:     cat = kcpu_isa_pkg::SINGLE_A_INH;
            kcpu_isa_pkg::BRA:      cat = kcpu_isa_pkg::SBRANCH;
            kcpu_isa_pkg::LBRA:     cat = kcpu_isa_pkg::LBRANCH;
            kcpu_isa_pkg::LDA_IDX: begin
                cat    = kcpu_isa_pkg::PARSE_IDX;
                nx_cat = kcpu_isa_pkg::SINGLE_ALU_IDX;
            end
            kcpu_isa_pkg::STA: begin
                cat    = kcpu_isa_pkg::PARSE_IDX;
                nx_cat = kcpu_isa_pkg::STORE8;
            end
            kcpu_isa_pkg::LEAX,
            kcpu_isa_pkg::JMP: begin   // jmp only loads the effective address
                cat    = kcpu_isa_pkg::PARSE_IDX;
                nx_cat = kcpu_isa_pkg::LEA;
            end
            default:                cat = kcpu_isa_pkg::BUSERROR;
        endcase
    end

    // postbyte to indexed category
    // register select covers x, y, u, s and pc, indirect is not handled
    always_comb begin
        if (postbyte[kcpu_isa_pkg::IDX_IND_BIT] || idx_reg > 3'd4) begin
            idx_cat = kcpu_isa_pkg::BUSERROR;
        end else begin
            idx_cat = kcpu_isa_pkg::IDX_MODE;
        end
    end

endmodule

//--- kcpu_ucode_rom.sv
`timescale 1ns/1ps

module kcpu_ucode_rom (
    input  logic                                 clk,
    input  logic [kcpu_ucode_pkg::UCODE_AW-1:0] addr,
    output kcpu_ucode_pkg::ucode_t               word
);

    kcpu_ucode_pkg::ucode_t nx_word;

    // one row per address, {flags, ctl}
    always_comb begin
        case (addr)
            {kcpu_isa_pkg::RESET, 4'd0}:          nx_word = {kcpu_ucode_pkg::UF_FETCH, 8'h80};
            {kcpu_isa_pkg::RESET, 4'd1}:          nx_word = {kcpu_ucode_pkg::UF_NI, 8'h00};
            // interrupt entries stack state, opcode already fetched
            {kcpu_isa_pkg::NMI, 4'd0}:            nx_word = {kcpu_ucode_pkg::UF_NONE, 8'h41};
            {kcpu_isa_pkg::NMI, 4'd1}:            nx_word = {kcpu_ucode_pkg::UF_NI, 8'h00};
            {kcpu_isa_pkg::FIRQ, 4'd0}:           nx_word = {kcpu_ucode_pkg::UF_NONE, 8'h42};
            {kcpu_isa_pkg::FIRQ, 4'd1}:           nx_word = {kcpu_ucode_pkg::UF_NI, 8'h00};
            {kcpu_isa_pkg::IRQ, 4'd0}:            nx_word = {kcpu_ucode_pkg::UF_NONE, 8'h43};
            {kcpu_isa_pkg::IRQ, 4'd1}:            nx_word = {kcpu_ucode_pkg::UF_NI, 8'h00};
            {kcpu_isa_pkg::NOPE, 4'd0}:           nx_word = {kcpu_ucode_pkg::UF_FETCH, 8'h00};
            {kcpu_isa_pkg::NOPE, 4'd1}:           nx_word = {kcpu_ucode_pkg::UF_NI, 8'h00};
            {kcpu_isa_pkg::SINGLE_ALU, 4'd0}:     nx_word = {kcpu_ucode_pkg::UF_FETCH, 8'h00};
            {kcpu_isa_pkg::SINGLE_ALU, 4'd1}:     nx_word = {kcpu_ucode_pkg::UF_FETCH, 8'h11};
            {kcpu_isa_pkg::SINGLE_ALU, 4'd2}:     nx_word = {kcpu_ucode_pkg::UF_NI, 8'h00};
            {kcpu_isa_pkg::SINGLE_ALU_16, 4'd0}:  nx_word = {kcpu_ucode_pkg::UF_FETCH, 8'h00};
            {kcpu_isa_pkg::SINGLE_ALU_16, 4'd1}:  nx_word = {kcpu_ucode_pkg::UF_FETCH, 8'h00};
            {kcpu_isa_pkg::SINGLE_ALU_16, 4'd2}:  nx_word = {kcpu_ucode_pkg::UF_FETCH, 8'h12};
            {kcpu_isa_pkg::SINGLE_ALU_16, 4'd3}:  nx_word = {kcpu_ucode_pkg::UF_NI, 8'h00};
            {kcpu_isa_pkg::SINGLE_A_INH, 4'd0}:   nx_word = {kcpu_ucode_pkg::UF_FETCH, 8'h13};
            {kcpu_isa_pkg::SINGLE_A_INH, 4'd1}:   nx_word = {kcpu_ucode_pkg::UF_NI, 8'h00};
            {kcpu_isa_pkg::PARSE_IDX, 4'd0}:      nx_word = {kcpu_ucode_pkg::UF_PB, 8'h00};
            {kcpu_isa_pkg::PARSE_IDX, 4'd1}:      nx_word = {kcpu_ucode_pkg::UF_IDX_JMP, 8'h00};
            {kcpu_isa_pkg::IDX_MODE, 4'd0}:       nx_word = {kcpu_ucode_pkg::UF_NONE, 8'h20};
            {kcpu_isa_pkg::IDX_MODE, 4'd1}:       nx_word = {kcpu_ucode_pkg::UF_IDX_RET, 8'h00};
            {kcpu_isa_pkg::SINGLE_ALU_IDX, 4'd0}: nx_word = {kcpu_ucode_pkg::UF_NONE, 8'h21};
            {kcpu_isa_pkg::SINGLE_ALU_IDX, 4'd1}: nx_word = {kcpu_ucode_pkg::UF_FETCH, 8'h11};
            {kcpu_isa_pkg::SINGLE_ALU_IDX, 4'd2}: nx_word = {kcpu_ucode_pkg::UF_NI, 8'h00};
            {kcpu_isa_pkg::STORE8, 4'd0}:         nx_word = {kcpu_ucode_pkg::UF_FETCH, 8'h22};
            {kcpu_isa_pkg::STORE8, 4'd1}:         nx_word = {kcpu_ucode_pkg::UF_NI, 8'h00};
            {kcpu_isa_pkg::LEA, 4'd0}:            nx_word = {kcpu_ucode_pkg::UF_FETCH, 8'h23};
            {kcpu_isa_pkg::LEA, 4'd1}:            nx_word = {kcpu_ucode_pkg::UF_NI, 8'h00};
            {kcpu_isa_pkg::SBRANCH, 4'd0}:        nx_word = {kcpu_ucode_pkg::UF_FETCH, 8'h00};
            {kcpu_isa_pkg::SBRANCH, 4'd1}:        nx_word = {kcpu_ucode_pkg::UF_FETCH, 8'h30};
            {kcpu_isa_pkg::SBRANCH, 4'd2}:        nx_word = {kcpu_ucode_pkg::UF_NI, 8'h00};
            {kcpu_isa_pkg::LBRANCH, 4'd0}:        nx_word = {kcpu_ucode_pkg::UF_FETCH, 8'h00};
            {kcpu_isa_pkg::LBRANCH, 4'd1}:        nx_word = {kcpu_ucode_pkg::UF_FETCH, 8'h00};
            {kcpu_isa_pkg::LBRANCH, 4'd2}:        nx_word = {kcpu_ucode_pkg::UF_FETCH, 8'h31};
            {kcpu_isa_pkg::LBRANCH, 4'd3}:        nx_word = {kcpu_ucode_pkg::UF_NI, 8'h00};
            {kcpu_isa_pkg::BUSERROR, 4'd0}:       nx_word = {kcpu_ucode_pkg::UF_NONE, 8'hff};
            default:                              nx_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        word <= nx_word;
    end

endmodule

//--- kcpu_irq_arb.sv
`timescale 1ns/1ps

module kcpu_irq_arb (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,
    input  logic [7:0]         cc,
    input  logic               nmi_n,
    input  logic               firq_n,
    input  logic               irq_n,
    input  logic               take,
    output logic               intsrv,
    output kcpu_isa_pkg::cat_t irq_cat,
    output logic [3:0]         intvec
);

    logic       nmin_l;
    logic       nmi_pend;
    logic       firq;
    logic       irq;
    logic [3:0] vec;

    assign firq   = !firq_n && !cc[kcpu_isa_pkg::CC_F];   // level, masked by F
    assign irq    = !irq_n && !cc[kcpu_isa_pkg::CC_I];    // level, masked by I
    assign intsrv = nmi_pend || firq || irq;

    // one-hot, zero when nothing is pending
    assign vec = {1'b0, nmi_pend, firq && !nmi_pend, irq && !nmi_pend && !firq};

    always_comb begin
        if (nmi_pend) begin
            irq_cat = kcpu_isa_pkg::NMI;
        end else if (firq) begin
            irq_cat = kcpu_isa_pkg::FIRQ;
        end else begin
            irq_cat = kcpu_isa_pkg::IRQ;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            nmin_l   <= 1'b1;
            nmi_pend <= 1'b0;
            intvec   <= 4'd0;
        end else if (cen) begin
            nmin_l <= nmi_n;
            if (take) begin
                intvec   <= vec;
                nmi_pend <= 1'b0;
            end
            if (!nmi_n && nmin_l) nmi_pend <= 1'b1;   // falling edge wins over take
        end
    end

endmodule

//--- kcpu_useq.sv
`timescale 1ns/1ps

module kcpu_useq (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 cen,
    input  kcpu_ucode_pkg::ucode_t               word,
    output logic [kcpu_ucode_pkg::UCODE_AW-1:0] addr,
    output logic                                 fetch_req,
    input  logic                                 fetch_busy,
    input  logic                                 byte_vld,
    input  logic [7:0]                           fetch_byte,
    input  kcpu_isa_pkg::cat_t                   cat,
    input  kcpu_isa_pkg::cat_t                   nx_cat,
    input  kcpu_isa_pkg::cat_t                   idx_cat,
    output logic [7:0]                           op,
    output logic [7:0]                           postbyte,
    input  logic                                 intsrv,
    input  kcpu_isa_pkg::cat_t                   irq_cat,
    output logic                                 take,
    output logic                                 op_start,
    output kcpu_isa_pkg::cat_t                   op_cat,
    output logic                                 buserror
);

    logic [kcpu_ucode_pkg::UCODE_AW-1:0] upc;   // address of the word on the ROM output
    logic                                wvld;
    logic                                wait_q;  // fetch issued for the current word
    logic                                pb_q;
    logic                                act;
    kcpu_isa_pkg::cat_t                  nx_q;

    // the current word completes when no fetch is outstanding
    assign act       = cen && wvld && !buserror && !fetch_busy;
    assign fetch_req = cen && wvld && !buserror && word.fetch && !wait_q;
    assign take      = act && word.ni;
    assign op_start  = act && (word.ni || word.idx_jmp || word.idx_ret);

    always_comb begin
        if (word.ni) begin
            op_cat = intsrv ? irq_cat : cat;
        end else if (word.idx_jmp) begin
            op_cat = idx_cat;
        end else begin
            op_cat = nx_q;
        end
    end

    // next address, read by the registered ROM
    always_comb begin
        if (op_start) begin
            addr = {op_cat, kcpu_ucode_pkg::ENTRY_ROW};
        end else if (act) begin
            addr = upc + 1'b1;
        end else begin
            addr = upc;   // stalled or frozen
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            upc      <= {kcpu_isa_pkg::RESET, kcpu_ucode_pkg::ENTRY_ROW};
            wvld     <= 1'b0;   // ROM output is stale for one cycle
            wait_q   <= 1'b0;
            pb_q     <= 1'b0;
            nx_q     <= kcpu_isa_pkg::NOPE;
            buserror <= 1'b0;
        end else begin
            wvld <= 1'b1;
            upc  <= addr;
            if (fetch_req) begin
                wait_q <= 1'b1;
                pb_q   <= word.pb;
            end else if (act) begin
                wait_q <= 1'b0;
            end
            if (take) nx_q <= nx_cat;   // follow-up for indexed opcodes
            if (op_start && op_cat == kcpu_isa_pkg::BUSERROR) buserror <= 1'b1;
        end
    end

    // fetched byte goes to the opcode or postbyte latch
    always_ff @(posedge clk) begin
        if (byte_vld) begin
            if (pb_q) begin
                postbyte <= fetch_byte;
            end else begin
                op <= fetch_byte;
            end
        end
    end

endmodule

//--- kcpu_fetch_wb.sv
`timescale 1ns/1ps

module kcpu_fetch_wb (
    input  logic             clk,
    input  logic             rst,
    kcpu_wb_if.master        wb,
    input  logic             fetch_req,
    output logic             fetch_busy,
    output logic             byte_vld,
    output logic [7:0]       fetch_byte
);

    logic        cyc;
    logic [15:0] fa;   // fetch address

    assign wb.cyc     = cyc;
    assign wb.stb     = cyc;
    assign wb.we      = 1'b0;   // reads only
    assign wb.adr     = fa;
    assign fetch_busy = fetch_req || cyc;

    always_ff @(posedge clk) begin
        if (rst) begin
            cyc      <= 1'b0;
            fa       <= 16'd0;
            byte_vld <= 1'b0;
        end else begin
            byte_vld <= 1'b0;
            if (cyc && wb.ack) begin
                cyc      <= 1'b0;   // drop cyc and stb after the ack edge
                fa       <= fa + 16'd1;
                byte_vld <= 1'b1;
            end else if (fetch_req && !cyc) begin
                cyc <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cyc && wb.ack) fetch_byte <= wb.dat_r;
    end

endmodule

//--- kcpu_ctrl_top.sv
`timescale 1ns/1ps

module kcpu_ctrl_top (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              cen,
    input  logic [7:0]                        cc,
    input  logic                              nmi_n,
    input  logic                              firq_n,
    input  logic                              irq_n,
    output logic                              wb_cyc,
    output logic                              wb_stb,
    output logic                              wb_we,
    output logic [15:0]                       wb_adr,
    input  logic [7:0]                        wb_dat_r,
    input  logic                              wb_ack,
    output logic [kcpu_ucode_pkg::CTL_W-1:0] ctl,
    output logic                              op_start,
    output kcpu_isa_pkg::cat_t                op_cat,
    output logic [3:0]                        intvec,
    output logic                              buserror
);

    kcpu_wb_if wb ();

    kcpu_ucode_pkg::ucode_t              word;
    logic [kcpu_ucode_pkg::UCODE_AW-1:0] addr;
    logic [7:0]                          op;
    logic [7:0]                          postbyte;
    logic [7:0]                          fetch_byte;
    kcpu_isa_pkg::cat_t                  cat;
    kcpu_isa_pkg::cat_t                  nx_cat;
    kcpu_isa_pkg::cat_t                  idx_cat;
    kcpu_isa_pkg::cat_t                  irq_cat;
    logic                                fetch_req;
    logic                                fetch_busy;
    logic                                byte_vld;
    logic                                intsrv;
    logic                                take;

    // bus out to plain ports
    assign wb_cyc   = wb.cyc;
    assign wb_stb   = wb.stb;
    assign wb_we    = wb.we;
    assign wb_adr   = wb.adr;
    assign wb.dat_r = wb_dat_r;
    assign wb.ack   = wb_ack;

    assign ctl = word.ctl;

    kcpu_opdecode u_dec (
        .op       (op),
        .postbyte (postbyte),
        .cat      (cat),
        .nx_cat   (nx_cat),
        .idx_cat  (idx_cat)
    );

    kcpu_ucode_rom u_rom (
        .clk  (clk),
        .addr (addr),
        .word (word)
    );

    kcpu_irq_arb u_arb (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .cc      (cc),
        .nmi_n   (nmi_n),
        .firq_n  (firq_n),
        .irq_n   (irq_n),
        .take    (take),
        .intsrv  (intsrv),
        .irq_cat (irq_cat),
        .intvec  (intvec)
    );

    kcpu_fetch_wb u_fetch (
        .clk        (clk),
        .rst        (rst),
        .wb         (wb.master),
        .fetch_req  (fetch_req),
        .fetch_busy (fetch_busy),
        .byte_vld   (byte_vld),
        .fetch_byte (fetch_byte)
    );

    kcpu_useq u_seq (
        .clk        (clk),
        .rst        (rst),
        .cen        (cen),
        .word       (word),
        .addr       (addr),
        .fetch_req  (fetch_req),
        .fetch_busy (fetch_busy),
        .byte_vld   (byte_vld),
        .fetch_byte (fetch_byte),
        .cat        (cat),
        .nx_cat     (nx_cat),
        .idx_cat    (idx_cat),
        .op         (op),
        .postbyte   (postbyte),
        .intsrv     (intsrv),
        .irq_cat    (irq_cat),
        .take       (take),
        .op_start   (op_start),
        .op_cat     (op_cat),
        .buserror   (buserror)
    );

endmodule

//--- tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

//--- tb_kcpu_ctrl.sv
`timescale 1ns/1ps

module tb_kcpu_ctrl;

    localparam int PROG_LEN    = 30;
    localparam int WATCHDOG_NS = (PROG_LEN * 40 + 200) * 8;

    logic        clk;
    logic        rst;
    logic        cen;
    logic [7:0]  cc;
    logic        nmi_n;
    logic        firq_n;
    logic        irq_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [15:0] wb_adr;
    logic [7:0]  wb_dat_r;
    logic        wb_ack;
    logic [7:0]  ctl;
    logic        op_start;
    logic [3:0]  intvec;
    logic        buserror;
    kcpu_isa_pkg::cat_t op_cat;

    logic [7:0]  mem [0:63];
    logic [15:0] next_adr;
    logic        rst_d;
    int          errors;
    int          starts;
    int          wait_cnt;
    integer      seed;
    kcpu_isa_pkg::cat_t exp_q[$];

    tb_clkgen clkgen_i (.clk(clk), .rst(rst));

    kcpu_ctrl_top kcpu_ctrl_top_i (
        .clk(clk), .rst(rst), .cen(cen), .cc(cc),
        .nmi_n(nmi_n), .firq_n(firq_n), .irq_n(irq_n),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .ctl(ctl), .op_start(op_start), .op_cat(op_cat),
        .intvec(intvec), .buserror(buserror)
    );

    // decode table as the testbench sees it
    function automatic kcpu_isa_pkg::cat_t op_category(input logic [7:0] op);
        case (op)
            8'h12, 8'h39:        return kcpu_isa_pkg::NOPE;
            8'h86, 8'h8b:        return kcpu_isa_pkg::SINGLE_ALU;
            8'hcc:               return kcpu_isa_pkg::SINGLE_ALU_16;
            8'h4c, 8'h5f:        return kcpu_isa_pkg::SINGLE_A_INH;
            8'h20:               return kcpu_isa_pkg::SBRANCH;
            8'h16:               return kcpu_isa_pkg::LBRANCH;
            8'ha6, 8'ha7, 8'h30, 8'h6e: return kcpu_isa_pkg::PARSE_IDX;
            default:             return kcpu_isa_pkg::BUSERROR;
        endcase
    endfunction

    function automatic kcpu_isa_pkg::cat_t follow_up(input logic [7:0] op);
        case (op)
            8'ha6:   return kcpu_isa_pkg::SINGLE_ALU_IDX;
            8'ha7:   return kcpu_isa_pkg::STORE8;
            default: return kcpu_isa_pkg::LEA;   // leax, jmp
        endcase
    endfunction

    // queue the routine entries one opcode produces
    task automatic expect_op(input logic [7:0] op);
        exp_q.push_back(op_category(op));
        if (op_category(op) == kcpu_isa_pkg::PARSE_IDX) begin
            exp_q.push_back(kcpu_isa_pkg::IDX_MODE);
            exp_q.push_back(follow_up(op));
        end
    endtask

    task automatic wait_for_starts(input int n);
        while (starts < n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // byte memory with 0 to 3 wait states
    always @(posedge clk) begin
        #1;
        if (rst || wb_ack) begin
            wb_ack = 1'b0;
        end else if (wb_cyc) begin
            if (wait_cnt == 0) begin
                wb_ack   = 1'b1;
                wb_dat_r = mem[wb_adr[5:0]];
                wait_cnt = $unsigned($random(seed)) % 4;
            end else begin
                wait_cnt = wait_cnt - 1;
            end
        end
    end

    always @(posedge clk) begin
        rst_d <= rst;
    end

    // routine entries in order
    always @(posedge clk) begin
        if (!rst && op_start) begin
            if (exp_q.size() == 0) begin
                errors = errors + 1;
                $display("unexpected routine entry, category %0d", op_cat);
            end else begin
                assert (op_cat == exp_q[0])
                else begin
                    errors = errors + 1;
                    $display("Mismatch op_cat entry %0d: expected %0d, actual %0d",
                             starts, exp_q[0], op_cat);
                end
                void'(exp_q.pop_front());
            end
            starts = starts + 1;
        end
    end

    // fetch order
    always @(posedge clk) begin
        if (!rst && wb_cyc && wb_ack) begin
            assert (wb_adr == next_adr)
            else begin
                errors = errors + 1;
                $display("Mismatch fetch_adr: expected %h, actual %h", next_adr, wb_adr);
            end
            next_adr <= next_adr + 16'd1;
        end
    end

    reset_state: assert property (@(posedge clk)
        rst_d |-> !wb_cyc && !op_start && !buserror && intvec == 4'd0)
        else begin
            errors = errors + 1;
            $display("outputs not idle during or right after reset");
        end

    stb_is_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb == wb_cyc)
        else begin
            errors = errors + 1;
            $display("Mismatch wb_stb: expected %b, actual %b", wb_cyc, wb_stb);
        end

    read_only: assert property (@(posedge clk) disable iff (rst) wb_cyc |-> !wb_we)
        else begin
            errors = errors + 1;
            $display("write cycle seen on the bus");
        end

    hold_until_ack: assert property (@(posedge clk) disable iff (rst)
        wb_cyc && !wb_ack |=> wb_cyc && $stable(wb_adr))
        else begin
            errors = errors + 1;
            $display("cyc or adr changed before ack");
        end

    drop_after_ack: assert property (@(posedge clk) disable iff (rst)
        wb_cyc && wb_ack |=> !wb_cyc)
        else begin
            errors = errors + 1;
            $display("cyc still high after the ack edge");
        end

    nmi_vec: assert property (@(posedge clk) disable iff (rst)
        op_start && op_cat == kcpu_isa_pkg::NMI |=> intvec == 4'b0100)
        else begin
            errors = errors + 1;
            $display("Mismatch intvec nmi: expected 0100, actual %b", intvec);
        end

    firq_vec: assert property (@(posedge clk) disable iff (rst)
        op_start && op_cat == kcpu_isa_pkg::FIRQ |=> intvec == 4'b0010)
        else begin
            errors = errors + 1;
            $display("Mismatch intvec firq: expected 0010, actual %b", intvec);
        end

    irq_vec: assert property (@(posedge clk) disable iff (rst)
        op_start && op_cat == kcpu_isa_pkg::IRQ |=> intvec == 4'b0001)
        else begin
            errors = errors + 1;
            $display("Mismatch intvec irq: expected 0001, actual %b", intvec);
        end

    buserror_sticky: assert property (@(posedge clk) disable iff (rst) buserror |=> buserror)
        else begin
            errors = errors + 1;
            $display("buserror dropped before reset");
        end

    frozen_bus: assert property (@(posedge clk) disable iff (rst) buserror |-> !wb_cyc)
        else begin
            errors = errors + 1;
            $display("bus cycle started after buserror");
        end

    // sequencer waits out the bus cycle and stays put after buserror
    stall_no_start: assert property (@(posedge clk) disable iff (rst)
        wb_cyc || buserror |-> !op_start)
        else begin
            errors = errors + 1;
            $display("routine entered while stalled on the bus or frozen");
        end

    stall_holds_ctl: assert property (@(posedge clk) disable iff (rst)
        wb_cyc || buserror |=> $stable(ctl))
        else begin
            errors = errors + 1;
            $display("ctl moved on while stalled on the bus or frozen");
        end

    initial begin
        logic [7:0] prog [0:PROG_LEN-1];
        int a;
        prog = '{8'h86, 8'h55, 8'h8b, 8'h01, 8'hcc, 8'h12, 8'h34, 8'h4c, 8'h5f, 8'h12,
                 8'h20, 8'h05, 8'h16, 8'h00, 8'h10, 8'h39, 8'ha6, 8'h00, 8'ha7, 8'h10,
                 8'h30, 8'h20, 8'h6e, 8'h40, 8'h12, 8'h12, 8'h12, 8'h12, 8'h12, 8'h01};
        for (a = 0; a < 64; a++) begin
            mem[a] = (a < PROG_LEN) ? prog[a] : 8'(a * 7 + 8'h5a);
        end
        cen      = 1'b1;
        cc       = 8'h00;
        nmi_n    = 1'b1;
        firq_n   = 1'b1;
        irq_n    = 1'b1;
        wb_ack   = 1'b0;
        wb_dat_r = 8'h00;
        next_adr = 16'd0;
        rst_d    = 1'b0;
        errors   = 0;
        starts   = 0;
        seed     = 32'h8c4b_33b5;
        wait_cnt = $unsigned($random(seed)) % 4;

        // opcodes at 0..24 are each one routine or an indexed triple
        foreach (prog[i]) begin
            if (i inside {0, 2, 4, 7, 8, 9, 10, 12, 15, 16, 18, 20, 22, 24}) expect_op(prog[i]);
        end
        exp_q.push_back(kcpu_isa_pkg::NMI);
        exp_q.push_back(kcpu_isa_pkg::FIRQ);
        exp_q.push_back(kcpu_isa_pkg::IRQ);
        for (a = 25; a < PROG_LEN; a++) expect_op(prog[a]);

        wait_for_starts(22);   // nop at 24 entered
        nmi_n  = 1'b0;
        firq_n = 1'b0;
        irq_n  = 1'b0;
        wait_for_starts(24);
        firq_n = 1'b1;
        wait_for_starts(25);
        irq_n = 1'b1;
        nmi_n = 1'b1;   // low through firq and irq entry, only the edge counts
        wait_for_starts(26);
        cc     = 8'h40;   // only F set so firq is masked
        firq_n = 1'b0;
        wait_for_starts(27);
        cc     = 8'h10;   // only I set so irq is masked
        firq_n = 1'b1;
        irq_n  = 1'b0;
        wait_for_starts(28);
        cc    = 8'h00;
        irq_n = 1'b1;

        while (!buserror) begin
            @(posedge clk);
            #1;
        end
        repeat (10) @(posedge clk);
        if (exp_q.size() != 0) begin
            errors = errors + 1;
            $display("%0d expected routine entries never happened", exp_q.size());
        end
        $display("result: %0d routine entries, %0d errors", starts, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not reach buserror within %0d ns", WATCHDOG_NS);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- vlog.f
kcpu_isa_pkg.sv
kcpu_ucode_pkg.sv
kcpu_wb_if.sv
kcpu_opdecode.sv
kcpu_ucode_rom.sv
kcpu_irq_arb.sv
kcpu_useq.sv
kcpu_fetch_wb.sv
kcpu_ctrl_top.sv
tb_clkgen.sv
tb_kcpu_ctrl.sv

//--- Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f vlog.f --top-module tb_kcpu_ctrl -o sim_kcpu

run: build
	./obj_dir/sim_kcpu | tee sim.log
	@if grep -q '\*\*\* FAILED \*\*\*' sim.log; then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' sim.log; then \
		echo "simulation ended without a result"; exit 1; \
	fi

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module tb_kcpu_ctrl

clean:
	rm -rf obj_dir sim.log
